//--- common/btb_pkg.sv
// Geometry, vector types and update FSM states for the branch target buffer.
// Imported by the BTB interface and RTL modules.
package btb_pkg;

    localparam int BTB_S_OFFSET = 2;  // word aligned instructions
    localparam int BTB_S_INDEX  = 3;
    localparam int BTB_SETS     = 2**BTB_S_INDEX;
    localparam int BTB_TAG_W    = 32 - BTB_S_INDEX - BTB_S_OFFSET;
    localparam int BTB_WAYS     = 2;

    // pc or branch target
    typedef logic [31:0] addr_t;

    typedef logic [BTB_S_INDEX-1:0] btb_index_t;

    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    // one-hot, bit n selects way n
    typedef logic [BTB_WAYS-1:0] way_mask_t;

    typedef enum logic [1:0]
    {
        UPD_IDLE,
        UPD_PROBE,  // update pc owns the read port
        UPD_WRITE   // probe result back, write to victim
    } upd_state_e;

endpackage : btb_pkg

//--- common/btb_update_if.sv
// Probe results and write commands between the BTB update FSM and datapath.
`timescale 1ns/1ps

interface btb_update_if;
    import btb_pkg::*;

    logic       probe_sel;      // read port follows upd_index
    btb_index_t upd_index;
    btb_tag_t   upd_tag;
    addr_t      upd_target;
    way_mask_t  wr_way;         // zero when idle
    way_mask_t  probe_hit_way;
    logic       probe_lru;      // way to replace

    modport control
    (
        output probe_sel, upd_index, upd_tag, upd_target, wr_way,
        input  probe_hit_way, probe_lru
    );

    modport datapath
    (
        input  probe_sel, upd_index, upd_tag, upd_target, wr_way,
        output probe_hit_way, probe_lru
    );

endinterface : btb_update_if

//--- btb/btb_array.sv
// One entry per BTB set with a registered read port and a separate write port.
// Read-first: a read and write to the same entry at one edge returns the old data.
`timescale 1ns/1ps

module btb_array #(
    parameter int width = 1
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                read,
    input  logic                load,
    input  btb_pkg::btb_index_t rindex,
    input  btb_pkg::btb_index_t windex,
    input  logic [width-1:0]    datain,
    output logic [width-1:0]    dataout
);
    import btb_pkg::*;

    logic [width-1:0] data [BTB_SETS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < BTB_SETS; i++)
                data[i] <= '0;
            dataout <= '0;
        end
        else
        begin
            if (read)
                dataout <= data[rindex];
            if (load)
                data[windex] <= datain;
        end
    end

endmodule : btb_array

//--- btb/btb_datapath.sv
// BTB storage: per-way tag, valid and target arrays plus a per-set LRU bit.
// Shares one read index between lookups and update probes; hit is known a cycle later.
`timescale 1ns/1ps

module btb_datapath
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           lookup_fire,
    input  btb_pkg::addr_t lookup_pc,
    btb_update_if.datapath upd,
    output logic           pred_hit,
    output btb_pkg::addr_t pred_target
);
    import btb_pkg::*;

    btb_index_t          rd_index;
    btb_tag_t            rd_tag;
    btb_index_t          rd_index_q;
    btb_tag_t            rd_tag_q;
    logic                lookup_q;
    btb_tag_t            tag_out [BTB_WAYS];
    addr_t               target_out [BTB_WAYS];
    logic [BTB_WAYS-1:0] valid_out;
    way_mask_t           hit_way;
    logic                upd_wr;
    logic                lru_load;
    logic                lru_in;
    btb_index_t          lru_windex;
    logic                lru_out;
    logic                lru_fwd_q;
    logic                lru_fwd_val_q;

    assign rd_index = upd.probe_sel ? upd.upd_index
                                    : lookup_pc[BTB_S_OFFSET +: BTB_S_INDEX];
    assign rd_tag   = upd.probe_sel ? upd.upd_tag : lookup_pc[31 -: BTB_TAG_W];

    // address behind the array outputs
    always_ff @(posedge clk)
    begin
        rd_index_q <= rd_index;
        rd_tag_q   <= rd_tag;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            lookup_q <= 1'b0;
        else
            lookup_q <= lookup_fire;
    end

    for (genvar w = 0; w < BTB_WAYS; w++)
    begin : g_way
        btb_array #(.width(BTB_TAG_W)) tag_array
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .read    (1'b1),
            .load    (upd.wr_way[w]),
            .rindex  (rd_index),
            .windex  (upd.upd_index),
            .datain  (upd.upd_tag),
            .dataout (tag_out[w])
        );

        btb_array #(.width(32)) target_array
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .read    (1'b1),
            .load    (upd.wr_way[w]),
            .rindex  (rd_index),
            .windex  (upd.upd_index),
            .datain  (upd.upd_target),
            .dataout (target_out[w])
        );

        btb_array #(.width(1)) valid_array
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .read    (1'b1),
            .load    (upd.wr_way[w]),
            .rindex  (rd_index),
            .windex  (upd.upd_index),
            .datain  (1'b1),
            .dataout (valid_out[w])
        );

        assign hit_way[w] = valid_out[w] && (tag_out[w] == rd_tag_q);
    end

    assign pred_hit          = |hit_way;
    assign pred_target       = hit_way[1] ? target_out[1] : target_out[0];
    assign upd.probe_hit_way = hit_way;

    // lru points away from the way just used
    assign upd_wr     = |upd.wr_way;
    assign lru_load   = upd_wr || (lookup_q && pred_hit);
    assign lru_windex = upd_wr ? upd.upd_index : rd_index_q;
    assign lru_in     = upd_wr ? upd.wr_way[0] : hit_way[0];

    btb_array #(.width(1)) lru_array
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .read    (1'b1),
        .load    (lru_load),
        .rindex  (rd_index),
        .windex  (lru_windex),
        .datain  (lru_in),
        .dataout (lru_out)
    );

    // A lookup hit can retire its LRU write on the same edge that an update
    // probe reads that set, so the fresh value is forwarded to the probe.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            lru_fwd_q <= 1'b0;
        else
            lru_fwd_q <= lru_load && (lru_windex == rd_index);
    end

    always_ff @(posedge clk)
    begin
        lru_fwd_val_q <= lru_in;
    end

    assign upd.probe_lru = lru_fwd_q ? lru_fwd_val_q : lru_out;

endmodule : btb_datapath

//--- btb/btb_update_ctrl.sv
// Update FSM for the BTB: accepts resolved branches, probes the set, then writes.
// Also owns the shared read port, so it gates lookups and times pred_valid.
`timescale 1ns/1ps

module btb_update_ctrl
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           upd_valid,
    output logic           upd_ready,
    input  btb_pkg::addr_t upd_pc,
    input  btb_pkg::addr_t upd_target,
    input  logic           lookup_valid,
    output logic           lookup_ready,
    output logic           lookup_fire,
    output logic           pred_valid,
    btb_update_if.control  upd
);
    import btb_pkg::*;

    upd_state_e state;
    upd_state_e state_next;
    logic       upd_fire;
    addr_t      pc_q;
    addr_t      target_q;

    assign upd_ready    = (state == UPD_IDLE);
    assign lookup_ready = (state != UPD_PROBE);  // probe owns the read port
    assign upd_fire     = upd_valid && upd_ready;
    assign lookup_fire  = lookup_valid && lookup_ready;

    always_comb
    begin
        unique case (state)
            UPD_IDLE:  state_next = upd_fire ? UPD_PROBE : UPD_IDLE;
            UPD_PROBE: state_next = UPD_WRITE;
            UPD_WRITE: state_next = UPD_IDLE;
            default:   state_next = UPD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= UPD_IDLE;
            pred_valid <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            pred_valid <= lookup_fire;  // array read is one cycle
        end
    end

    always_ff @(posedge clk)
    begin
        if (upd_fire)
        begin
            pc_q     <= upd_pc;
            target_q <= upd_target;
        end
    end

    assign upd.probe_sel  = (state == UPD_PROBE);
    assign upd.upd_index  = pc_q[BTB_S_OFFSET +: BTB_S_INDEX];
    assign upd.upd_tag    = pc_q[31 -: BTB_TAG_W];
    assign upd.upd_target = target_q;

    // overwrite the way holding this pc, else the lru way
    always_comb
    begin
        upd.wr_way = '0;
        if (state == UPD_WRITE)
        begin
            if (|upd.probe_hit_way)
                upd.wr_way = upd.probe_hit_way;
            else
                upd.wr_way = way_mask_t'(1) << upd.probe_lru;
        end
    end

endmodule : btb_update_ctrl

//--- design/btb_top.sv
// Top level of the BTB: update FSM and storage datapath joined by btb_update_if.
// Lookup and update ports are plain valid/ready signals for the fetch and execute stages.
`timescale 1ns/1ps

module btb_top
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           lookup_valid,
    input  btb_pkg::addr_t lookup_pc,
    output logic           lookup_ready,
    output logic           pred_valid,
    output logic           pred_hit,
    output btb_pkg::addr_t pred_target,
    input  logic           upd_valid,
    input  btb_pkg::addr_t upd_pc,
    input  btb_pkg::addr_t upd_target,
    output logic           upd_ready
);

    logic lookup_fire;

    btb_update_if upd_bus ();

    btb_update_ctrl u_ctrl
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .upd_valid    (upd_valid),
        .upd_ready    (upd_ready),
        .upd_pc       (upd_pc),
        .upd_target   (upd_target),
        .lookup_valid (lookup_valid),
        .lookup_ready (lookup_ready),
        .lookup_fire  (lookup_fire),
        .pred_valid   (pred_valid),
        .upd          (upd_bus.control)
    );

    btb_datapath u_datapath
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_fire (lookup_fire),
        .lookup_pc   (lookup_pc),
        .upd         (upd_bus.datapath),
        .pred_hit    (pred_hit),
        .pred_target (pred_target)
    );

endmodule : btb_top

//--- sim/btb_assertions.sv
// Handshake and timing checks for the BTB, bound onto btb_top.
`timescale 1ns/1ps

module btb_assertions
(
    input logic       clk,
    input logic       rst_n,
    input logic       lookup_valid,
    input logic       lookup_ready,
    input logic       pred_valid,
    input logic       upd_valid,
    input logic       upd_ready,
    input logic [1:0] wr_way
);

    pred_follows_lookup: assert property (@(posedge clk) disable iff (!rst_n)
        (lookup_valid && lookup_ready) |=> pred_valid)
        else $error("pred_valid missing one cycle after an accepted lookup");

    upd_busy_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
        (upd_valid && upd_ready) |=> !upd_ready ##1 !upd_ready)
        else $error("upd_ready rose too early after an accepted update");

    // probe cycle is the one right after an accepted update
    no_lookup_in_probe: assert property (@(posedge clk) disable iff (!rst_n)
        (upd_valid && upd_ready) |=> !lookup_ready)
        else $error("lookup_ready high during the probe cycle");

    wr_way_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(wr_way))
        else $error("wr_way has more than one way selected");

endmodule : btb_assertions

bind btb_top btb_assertions u_assertions
(
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup_valid (lookup_valid),
    .lookup_ready (lookup_ready),
    .pred_valid   (pred_valid),
    .upd_valid    (upd_valid),
    .upd_ready    (upd_ready),
    .wr_way       (upd_bus.wr_way)
);

//--- sim/btb_tb.sv
// Directed testbench for btb_top with a behavioral 2-way BTB model.
// Every pred_valid is compared against the model; run stops at a cycle limit.
`timescale 1ns/1ps

module btb_tb;
    import btb_pkg::*;

    localparam int MAX_CYCLES = 3000;

    logic  clk;
    logic  rst_n;
    logic  lookup_valid;
    addr_t lookup_pc;
    logic  lookup_ready;
    logic  pred_valid;
    logic  pred_hit;
    addr_t pred_target;
    logic  upd_valid;
    addr_t upd_pc;
    addr_t upd_target;
    logic  upd_ready;

    int errors = 0;
    int cycles = 0;
    int seed = 46583;

    // model state
    logic     m_valid [8][2];
    btb_tag_t m_tag [8][2];
    addr_t    m_tgt [8][2];
    logic     m_lru [8];
    logic     exp_hit_q [$];
    addr_t    exp_tgt_q [$];
    logic     lk_fire_next = 1'b0;
    logic     up_fire_next = 1'b0;
    int       upd_wait = 0;
    addr_t    pend_pc;
    addr_t    pend_tgt;
    logic     defer_on = 1'b0;
    int       defer_idx;
    logic     defer_val;

    btb_top uut
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .lookup_ready (lookup_ready),
        .pred_valid   (pred_valid),
        .pred_hit     (pred_hit),
        .pred_target  (pred_target),
        .upd_valid    (upd_valid),
        .upd_pc       (upd_pc),
        .upd_target   (upd_target),
        .upd_ready    (upd_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("run stopped: cycle limit of %0d reached", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // way holding pc or -1 on a miss
    function automatic int model_way(input addr_t pc);
        int idx;
        idx = int'(pc[4:2]);
        for (int w = 0; w < 2; w++)
            if (m_valid[idx][w] && m_tag[idx][w] == pc[31:5])
                return w;
        return -1;
    endfunction

    always @(negedge clk)
    begin : model
        int    w;
        int    idx;
        logic  eh;
        addr_t et;
        logic  new_defer;
        int    new_idx;
        logic  new_val;
        if (rst_n)
        begin
            if (pred_valid)
            begin
                assert (exp_hit_q.size() > 0)
                else
                begin
                    $display("pred_valid raised at %0t with no lookup accepted", $time);
                    errors++;
                end
                if (exp_hit_q.size() > 0)
                begin
                    eh = exp_hit_q.pop_front();
                    et = exp_tgt_q.pop_front();
                    assert (pred_hit === eh)
                    else
                    begin
                        $display("[ERROR] %0t pred_hit exp %b got %b", $time, eh, pred_hit);
                        errors++;
                    end
                    if (eh)
                        assert (pred_target === et)
                        else
                        begin
                            $display("[ERROR] %0t pred_target exp %h got %h",
                                     $time, et, pred_target);
                            errors++;
                        end
                end
            end
            else
                assert (exp_hit_q.size() == 0)
                else
                begin
                    $display("lookup accepted at %0t but pred_valid stayed low", $time);
                    errors++;
                    exp_hit_q.delete();
                    exp_tgt_q.delete();
                end
            lk_fire_next = lookup_valid && lookup_ready;
            up_fire_next = upd_valid && upd_ready;
            // lookup reads contents from before this edge's writes
            new_defer = 1'b0;
            if (lk_fire_next)
            begin
                w = model_way(lookup_pc);
                idx = int'(lookup_pc[4:2]);
                exp_hit_q.push_back(w >= 0);
                exp_tgt_q.push_back(w >= 0 ? m_tgt[idx][w] : '0);
                new_defer = (w >= 0);
                new_idx = idx;
                new_val = (w == 0);
            end
            if (defer_on)
                m_lru[defer_idx] = defer_val;
            if (upd_wait > 0)
            begin
                upd_wait--;
                if (upd_wait == 0)
                begin
                    idx = int'(pend_pc[4:2]);
                    w = model_way(pend_pc);
                    if (w < 0)
                        w = int'(m_lru[idx]);
                    m_valid[idx][w] = 1'b1;
                    m_tag[idx][w] = pend_pc[31:5];
                    m_tgt[idx][w] = pend_tgt;
                    m_lru[idx] = (w == 0);
                end
            end
            defer_on = new_defer;
            defer_idx = new_idx;
            defer_val = new_val;
            if (up_fire_next)
            begin
                upd_wait = 2;
                pend_pc = upd_pc;
                pend_tgt = upd_target;
            end
        end
    end

    task automatic send_lookup(input addr_t pc);
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_pc <= pc;
        @(negedge clk);
        while (!lookup_ready)
            @(negedge clk);
        @(posedge clk);
        lookup_valid <= 1'b0;
    endtask

    task automatic lookup_expect(input addr_t pc, input logic exp_hit);
        send_lookup(pc);
        @(negedge clk);
        assert (pred_hit === exp_hit)
        else
        begin
            $display("[ERROR] %0t pred_hit exp %b got %b (pc %h)",
                     $time, exp_hit, pred_hit, pc);
            errors++;
        end
    endtask

    task automatic send_update(input addr_t pc, input addr_t tgt);
        @(posedge clk);
        upd_valid <= 1'b1;
        upd_pc <= pc;
        upd_target <= tgt;
        @(negedge clk);
        while (!upd_ready)
            @(negedge clk);
        @(posedge clk);
        upd_valid <= 1'b0;
        @(negedge clk);
        while (!upd_ready)  // back in idle once written
            @(negedge clk);
    endtask

    task automatic empty_after_reset();
        lookup_expect(32'h0000_1000, 1'b0);
        lookup_expect(32'h8000_0044, 1'b0);
        lookup_expect(32'hdead_beec, 1'b0);
    endtask

    task automatic update_then_lookup();
        send_update(32'h0000_2008, 32'h0000_3000);
        lookup_expect(32'h0000_2008, 1'b1);
        lookup_expect(32'h0000_200c, 1'b0);  // other set
    endtask

    task automatic both_ways_used();
        send_update(32'h0000_4010, 32'h0000_5000);
        send_update(32'h0000_6010, 32'h0000_7000);
        lookup_expect(32'h0000_4010, 1'b1);
        lookup_expect(32'h0000_6010, 1'b1);
    endtask

    task automatic lru_replacement();
        // three new tags in set 4 push out both earlier entries
        send_update(32'h0001_0010, 32'h0000_aaa0);
        send_update(32'h0002_0010, 32'h0000_bbb0);
        send_update(32'h0003_0010, 32'h0000_ccc0);
        lookup_expect(32'h0000_4010, 1'b0);
        lookup_expect(32'h0000_6010, 1'b0);
        // set 6 gets A in way0 and B in way1, and the hit on A leaves B as lru
        send_update(32'h0000_4018, 32'h0000_a000);
        send_update(32'h0000_5018, 32'h0000_b000);
        lookup_expect(32'h0000_4018, 1'b1);
        send_update(32'h0000_6018, 32'h0000_c000);
        lookup_expect(32'h0000_4018, 1'b1);
        lookup_expect(32'h0000_5018, 1'b0);
        lookup_expect(32'h0000_6018, 1'b1);
    endtask

    task automatic target_in_place();
        send_update(32'h0000_6018, 32'h0000_d000);  // new target in place
        lookup_expect(32'h0000_6018, 1'b1);
        lookup_expect(32'h0000_4018, 1'b1);
    endtask

    function automatic addr_t pool_pc(input logic [3:0] k);
        return {25'd0, k[3:2], 1'b0, k[1:0], 2'b00};  // 4 tags over 4 sets
    endfunction

    task automatic random_mix();
        int r;
        for (int i = 0; i < 400; i++)
        begin
            @(posedge clk);
            if (!lookup_valid || lk_fire_next)
            begin
                r = $random(seed);
                lookup_valid <= r[0];
                lookup_pc <= pool_pc(r[4:1]);
            end
            if (!upd_valid || up_fire_next)
            begin
                r = $random(seed);
                upd_valid <= r[0] & r[1];
                upd_pc <= pool_pc(r[5:2]);
                upd_target <= {r[31:2], 2'b00};
            end
        end
        while (lookup_valid || upd_valid)
        begin
            @(posedge clk);
            if (lk_fire_next)
                lookup_valid <= 1'b0;
            if (up_fire_next)
                upd_valid <= 1'b0;
        end
        repeat (4) @(posedge clk);
    endtask

    initial
    begin
        rst_n = 1'b0;
        lookup_valid = 1'b0;
        lookup_pc = '0;
        upd_valid = 1'b0;
        upd_pc = '0;
        upd_target = '0;
        for (int s = 0; s < 8; s++)
        begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++)
            begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
                m_tgt[s][w] = '0;
            end
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        empty_after_reset();
        update_then_lookup();
        both_ways_used();
        lru_replacement();
        target_in_place();
        random_mix();

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule : btb_tb

//--- filelist.f
common/btb_pkg.sv
common/btb_update_if.sv
btb/btb_array.sv
btb/btb_datapath.sv
btb/btb_update_ctrl.sv
design/btb_top.sv
sim/btb_assertions.sv
sim/btb_tb.sv

//--- run.sh
#!/bin/sh
# Builds the BTB testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module btb_tb -o btb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/btb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi

exit 0
